// ==== source/stream_pkg.sv ====
package stream_pkg;

    //////////////////////////////////////////////////////////////////////
    // stream word layout
    //////////////////////////////////////////////////////////////////////

    // width of one stream word
    localparam int DATA_WIDTH = 32;

    // one byte enable per data byte
    localparam int KEEP_WIDTH = DATA_WIDTH / 8;

    //////////////////////////////////////////////////////////////////////
    // scheduling
    //////////////////////////////////////////////////////////////////////

    localparam int RANK_WIDTH = 8;

    typedef logic [DATA_WIDTH-1:0] data_t;

    typedef logic [KEEP_WIDTH-1:0] keep_t;

    // lower rank leaves earlier
    typedef logic [RANK_WIDTH-1:0] rank_t;

endpackage

// ==== source/storage_pkg.sv ====
package storage_pkg;

    //////////////////////////////////////////////////////////////////////
    // word buffer
    //////////////////////////////////////////////////////////////////////

    localparam int BUF_DEPTH = 64;
    localparam int ADDR_WIDTH = 6;

    // one link table entry always stays spare
    localparam int BUF_CAPACITY = BUF_DEPTH - 1;

    // almost full once remaining space drops to this
    localparam int ALMOST_FULL_MARGIN = 8;

    // count range is 0 up to BUF_CAPACITY
    localparam int COUNT_WIDTH = ADDR_WIDTH + 1;

    //////////////////////////////////////////////////////////////////////
    // calendar
    //////////////////////////////////////////////////////////////////////

    localparam int PIFO_DEPTH = 8;
    localparam int PIFO_COUNT_WIDTH = $clog2(PIFO_DEPTH) + 1;

    typedef logic [ADDR_WIDTH-1:0] buf_addr_t;
    typedef logic [COUNT_WIDTH-1:0] count_t;
    typedef logic [PIFO_COUNT_WIDTH-1:0] pifo_count_t;

    typedef enum logic [1:0] {DEQ_IDLE, DEQ_FETCH, DEQ_SEND} deq_state_t;

endpackage

// ==== source/free_list_manager.sv ====
`timescale 1ns/1ps

module free_list_manager
(
    input  logic                   axis_aclk,
    input  logic                   axis_resetn,
    input  logic                   wr_en,
    input  logic                   wr_last,
    input  logic                   rd_en,
    input  storage_pkg::buf_addr_t rd_addr,
    output storage_pkg::buf_addr_t wr_addr,
    output storage_pkg::buf_addr_t pkt_sop_addr,
    output storage_pkg::buf_addr_t next_addr,
    output storage_pkg::count_t    m_buffer_counter,
    output storage_pkg::count_t    m_buffer_remain_size,
    output logic                   m_is_buffer_almost_full
);

    import storage_pkg::*;

    // shared by free list and packet chains
    buf_addr_t link_table [BUF_DEPTH];

    buf_addr_t fl_head;
    buf_addr_t fl_tail;
    buf_addr_t sop_addr;
    buf_addr_t head_link;
    count_t    counter_next;
    count_t    remain_next;

    assign head_link    = link_table[fl_head];
    assign wr_addr      = fl_head;
    assign pkt_sop_addr = sop_addr;

    // successor of the word being read
    assign next_addr = link_table[rd_addr];

    //////////////////////////////////////////////////////////////////////
    // link table
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            // chain 0 -> 1 -> ... -> 63, last link wraps to 0
            for (int i = 0; i < BUF_DEPTH; i++)
                link_table[i] <= buf_addr_t'(i + 1);
        end
        else if (rd_en)
        begin
            // freed word hangs off the old tail
            link_table[fl_tail] <= rd_addr;
        end
    end

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            fl_head  <= '0;
            fl_tail  <= buf_addr_t'(BUF_DEPTH - 1);
            sop_addr <= '0;
        end
        else
        begin
            if (wr_en)
            begin
                fl_head <= head_link;
                // next packet starts at the new head
                if (wr_last)
                    sop_addr <= head_link;
            end
            if (rd_en)
                fl_tail <= rd_addr;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // statistics
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        counter_next = m_buffer_counter;
        if (wr_en && !rd_en)
            counter_next = m_buffer_counter + 1'b1;
        else if (rd_en && !wr_en)
            counter_next = m_buffer_counter - 1'b1;
        remain_next = count_t'(BUF_CAPACITY) - counter_next;
    end

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            m_buffer_counter        <= '0;
            m_buffer_remain_size    <= count_t'(BUF_CAPACITY);
            m_is_buffer_almost_full <= 1'b0;
        end
        else
        begin
            m_buffer_counter        <= counter_next;
            m_buffer_remain_size    <= remain_next;
            m_is_buffer_almost_full <= (remain_next <= count_t'(ALMOST_FULL_MARGIN));
        end
    end

endmodule

// ==== source/pkt_buffer.sv ====
`timescale 1ns/1ps

module pkt_buffer
(
    input  logic                   axis_aclk,
    input  logic                   wr_en,
    input  storage_pkg::buf_addr_t wr_addr,
    input  stream_pkg::data_t      wr_data,
    input  stream_pkg::keep_t      wr_keep,
    input  logic                   wr_last,
    input  logic                   rd_en,
    input  storage_pkg::buf_addr_t rd_addr,
    output stream_pkg::data_t      rd_data,
    output stream_pkg::keep_t      rd_keep,
    output logic                   rd_last
);

    import stream_pkg::*;
    import storage_pkg::*;

    data_t mem_data [BUF_DEPTH];
    keep_t mem_keep [BUF_DEPTH];
    logic  mem_last [BUF_DEPTH];

    // write port at the free list head
    always_ff @(posedge axis_aclk)
    begin
        if (wr_en)
        begin
            mem_data[wr_addr] <= wr_data;
            mem_keep[wr_addr] <= wr_keep;
            mem_last[wr_addr] <= wr_last;
        end
    end

    // registered read, data one cycle after rd_en
    always_ff @(posedge axis_aclk)
    begin
        if (rd_en)
        begin
            rd_data <= mem_data[rd_addr];
            rd_keep <= mem_keep[rd_addr];
            rd_last <= mem_last[rd_addr];
        end
    end

endmodule

// ==== source/pifo_calendar.sv ====
`timescale 1ns/1ps

module pifo_calendar
(
    input  logic                   axis_aclk,
    input  logic                   axis_resetn,
    input  logic                   wr_valid,
    input  logic                   wr_last,
    input  stream_pkg::rank_t      insert_rank,
    input  storage_pkg::buf_addr_t insert_addr,
    input  logic                   pop,
    output logic                   head_valid,
    output stream_pkg::rank_t      head_rank,
    output storage_pkg::buf_addr_t head_addr,
    output logic                   m_is_pifo_full
);

    import stream_pkg::*;
    import storage_pkg::*;

    // entry 0 is the best, valid entries are 0 .. count_q-1
    rank_t       rank_q  [PIFO_DEPTH];
    buf_addr_t   addr_q  [PIFO_DEPTH];
    rank_t       rank_nx [PIFO_DEPTH];
    buf_addr_t   addr_nx [PIFO_DEPTH];
    pifo_count_t count_q;
    pifo_count_t ins_pos;
    pifo_count_t slot;
    logic        insert;
    logic        do_insert;
    logic        do_pop;

    // packet is complete on its last word
    assign insert = wr_valid && wr_last;

    assign head_valid     = (count_q != '0);
    assign head_rank      = rank_q[0];
    assign head_addr      = addr_q[0];
    assign m_is_pifo_full = (count_q == pifo_count_t'(PIFO_DEPTH));

    assign do_pop    = pop && head_valid;
    assign do_insert = insert && (!m_is_pifo_full || do_pop);

    //////////////////////////////////////////////////////////////////////
    // insert position
    //////////////////////////////////////////////////////////////////////

    // behind every entry of equal or lower rank
    always_comb
    begin
        ins_pos = '0;
        for (int i = 0; i < PIFO_DEPTH; i++)
        begin
            if (pifo_count_t'(i) < count_q && rank_q[i] <= insert_rank)
                ins_pos = ins_pos + 1'b1;
        end
    end

    // popped head no longer counts
    assign slot = (do_pop && ins_pos != '0) ? ins_pos - 1'b1 : ins_pos;

    always_comb
    begin
        for (int j = 0; j < PIFO_DEPTH; j++)
        begin
            rank_nx[j] = rank_q[j];
            addr_nx[j] = addr_q[j];
        end
        if (do_pop)
        begin
            for (int j = 0; j < PIFO_DEPTH - 1; j++)
            begin
                rank_nx[j] = rank_q[j + 1];
                addr_nx[j] = addr_q[j + 1];
            end
        end
        if (do_insert)
        begin
            // entries behind the slot move back one place
            for (int j = 1; j < PIFO_DEPTH; j++)
            begin
                if (pifo_count_t'(j) > slot)
                begin
                    rank_nx[j] = do_pop ? rank_q[j] : rank_q[j - 1];
                    addr_nx[j] = do_pop ? addr_q[j] : addr_q[j - 1];
                end
            end
            for (int j = 0; j < PIFO_DEPTH; j++)
            begin
                if (pifo_count_t'(j) == slot)
                begin
                    rank_nx[j] = insert_rank;
                    addr_nx[j] = insert_addr;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge axis_aclk)
    begin
        for (int j = 0; j < PIFO_DEPTH; j++)
        begin
            rank_q[j] <= rank_nx[j];
            addr_q[j] <= addr_nx[j];
        end
    end

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
            count_q <= '0;
        else
            count_q <= count_q + pifo_count_t'(do_insert) - pifo_count_t'(do_pop);
    end

endmodule

// ==== source/dequeue_ctrl.sv ====
`timescale 1ns/1ps

module dequeue_ctrl
(
    input  logic                   axis_aclk,
    input  logic                   axis_resetn,
    input  logic                   head_valid,
    input  stream_pkg::rank_t      head_rank,
    input  storage_pkg::buf_addr_t head_addr,
    output logic                   pop,
    output logic                   rd_en,
    output storage_pkg::buf_addr_t rd_addr,
    input  storage_pkg::buf_addr_t next_addr,
    input  stream_pkg::data_t      rd_data,
    input  stream_pkg::keep_t      rd_keep,
    input  logic                   rd_last,
    input  logic                   m_axis_tready,
    output logic                   m_axis_tvalid,
    output stream_pkg::data_t      m_axis_tdata,
    output stream_pkg::keep_t      m_axis_tkeep,
    output logic                   m_axis_tlast,
    output stream_pkg::rank_t      m_axis_trank
);

    import storage_pkg::*;

    deq_state_t state;

    // link of the word last read, captured before that word is freed
    buf_addr_t  next_addr_q;
    logic       word_done;

    assign word_done = m_axis_tvalid && m_axis_tready;

    //////////////////////////////////////////////////////////////////////
    // read and pop requests
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        pop     = 1'b0;
        rd_en   = 1'b0;
        rd_addr = next_addr_q;
        case (state)
            DEQ_IDLE:
            begin
                // start a packet only toward a ready sink
                if (m_axis_tready && head_valid)
                begin
                    pop     = 1'b1;
                    rd_en   = 1'b1;
                    rd_addr = head_addr;
                end
            end
            DEQ_SEND:
            begin
                if (word_done && !m_axis_tlast)
                    rd_en = 1'b1;
            end
            default:
            begin
                rd_en = 1'b0;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // state and output valid
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            state         <= DEQ_IDLE;
            m_axis_tvalid <= 1'b0;
        end
        else
        begin
            case (state)
                DEQ_IDLE:
                begin
                    if (pop)
                        state <= DEQ_FETCH;
                end
                DEQ_FETCH:
                begin
                    // read data is back, present it
                    m_axis_tvalid <= 1'b1;
                    state         <= DEQ_SEND;
                end
                DEQ_SEND:
                begin
                    if (word_done)
                    begin
                        m_axis_tvalid <= 1'b0;
                        state         <= m_axis_tlast ? DEQ_IDLE : DEQ_FETCH;
                    end
                end
                default:
                begin
                    state <= DEQ_IDLE;
                end
            endcase
        end
    end

    // payload, held while valid waits for ready
    always_ff @(posedge axis_aclk)
    begin
        if (rd_en)
            next_addr_q <= next_addr;
        if (pop)
            m_axis_trank <= head_rank;
        if (state == DEQ_FETCH)
        begin
            m_axis_tdata <= rd_data;
            m_axis_tkeep <= rd_keep;
            m_axis_tlast <= rd_last;
        end
    end

endmodule

// ==== source/pkt_queue_top.sv ====
`timescale 1ns/1ps

module pkt_queue_top
(
    input  logic                axis_aclk,
    input  logic                axis_resetn,
    input  logic                s_axis_tvalid,
    input  stream_pkg::data_t   s_axis_tdata,
    input  stream_pkg::keep_t   s_axis_tkeep,
    input  logic                s_axis_tlast,
    input  stream_pkg::rank_t   s_axis_trank,
    input  logic                m_axis_tready,
    output logic                m_axis_tvalid,
    output stream_pkg::data_t   m_axis_tdata,
    output stream_pkg::keep_t   m_axis_tkeep,
    output logic                m_axis_tlast,
    output stream_pkg::rank_t   m_axis_trank,
    output storage_pkg::count_t m_buffer_counter,
    output storage_pkg::count_t m_buffer_remain_size,
    output logic                m_is_buffer_almost_full,
    output logic                m_is_pifo_full
);

    import stream_pkg::*;
    import storage_pkg::*;

    buf_addr_t wr_addr;
    buf_addr_t pkt_sop_addr;
    buf_addr_t next_addr;
    buf_addr_t rd_addr;
    buf_addr_t head_addr;
    rank_t     head_rank;
    data_t     rd_data;
    keep_t     rd_keep;
    logic      rd_last;
    logic      rd_en;
    logic      pop;
    logic      head_valid;

    //////////////////////////////////////////////////////////////////////
    // enqueue side
    //////////////////////////////////////////////////////////////////////

    free_list_manager u_free_list_manager
    (
        .axis_aclk               (axis_aclk),
        .axis_resetn             (axis_resetn),
        .wr_en                   (s_axis_tvalid),
        .wr_last                 (s_axis_tlast),
        .rd_en                   (rd_en),
        .rd_addr                 (rd_addr),
        .wr_addr                 (wr_addr),
        .pkt_sop_addr            (pkt_sop_addr),
        .next_addr               (next_addr),
        .m_buffer_counter        (m_buffer_counter),
        .m_buffer_remain_size    (m_buffer_remain_size),
        .m_is_buffer_almost_full (m_is_buffer_almost_full)
    );

    pkt_buffer u_pkt_buffer
    (
        .axis_aclk (axis_aclk),
        .wr_en     (s_axis_tvalid),
        .wr_addr   (wr_addr),
        .wr_data   (s_axis_tdata),
        .wr_keep   (s_axis_tkeep),
        .wr_last   (s_axis_tlast),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .rd_keep   (rd_keep),
        .rd_last   (rd_last)
    );

    pifo_calendar u_pifo_calendar
    (
        .axis_aclk      (axis_aclk),
        .axis_resetn    (axis_resetn),
        .wr_valid       (s_axis_tvalid),
        .wr_last        (s_axis_tlast),
        .insert_rank    (s_axis_trank),
        .insert_addr    (pkt_sop_addr),
        .pop            (pop),
        .head_valid     (head_valid),
        .head_rank      (head_rank),
        .head_addr      (head_addr),
        .m_is_pifo_full (m_is_pifo_full)
    );

    //////////////////////////////////////////////////////////////////////
    // dequeue side
    //////////////////////////////////////////////////////////////////////

    dequeue_ctrl u_dequeue_ctrl
    (
        .axis_aclk     (axis_aclk),
        .axis_resetn   (axis_resetn),
        .head_valid    (head_valid),
        .head_rank     (head_rank),
        .head_addr     (head_addr),
        .pop           (pop),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .next_addr     (next_addr),
        .rd_data       (rd_data),
        .rd_keep       (rd_keep),
        .rd_last       (rd_last),
        .m_axis_tready (m_axis_tready),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tkeep  (m_axis_tkeep),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_trank  (m_axis_trank)
    );

endmodule

// ==== bench/tb_pkt_queue.sv ====
`timescale 1ns/1ps

module tb_pkt_queue;

    import stream_pkg::*;
    import storage_pkg::*;

    localparam int MAX_PKTS   = 64;
    localparam int MAX_LEN    = 6;
    localparam int WAIT_LIMIT = 4000;

    logic   axis_aclk;
    logic   axis_resetn;
    logic   s_axis_tvalid;
    data_t  s_axis_tdata;
    keep_t  s_axis_tkeep;
    logic   s_axis_tlast;
    rank_t  s_axis_trank;
    logic   m_axis_tready = 1'b0;
    logic   m_axis_tvalid;
    data_t  m_axis_tdata;
    keep_t  m_axis_tkeep;
    logic   m_axis_tlast;
    rank_t  m_axis_trank;
    count_t m_buffer_counter;
    count_t m_buffer_remain_size;
    logic   m_is_buffer_almost_full;
    logic   m_is_pifo_full;

    // reference model, one slot per packet id
    data_t  pkt_data [MAX_PKTS][MAX_LEN];
    keep_t  pkt_keep [MAX_PKTS][MAX_LEN];
    rank_t  pkt_rank [MAX_PKTS];
    int     pkt_len  [MAX_PKTS];
    int     pending  [$];
    int     next_id;

    integer      seed;
    logic [31:0] ready_rand;
    int          ready_mode = 0;
    logic        ordered = 1'b1;
    int          cur_id = -1;
    int          word_idx = 0;
    logic        was_stalled = 1'b0;
    data_t       held_data;
    keep_t       held_keep;
    logic        held_last;
    rank_t       held_rank;

    always #2 axis_aclk = ~axis_aclk;

    pkt_queue_top UUT
    (
        .axis_aclk               (axis_aclk),
        .axis_resetn             (axis_resetn),
        .s_axis_tvalid           (s_axis_tvalid),
        .s_axis_tdata            (s_axis_tdata),
        .s_axis_tkeep            (s_axis_tkeep),
        .s_axis_tlast            (s_axis_tlast),
        .s_axis_trank            (s_axis_trank),
        .m_axis_tready           (m_axis_tready),
        .m_axis_tvalid           (m_axis_tvalid),
        .m_axis_tdata            (m_axis_tdata),
        .m_axis_tkeep            (m_axis_tkeep),
        .m_axis_tlast            (m_axis_tlast),
        .m_axis_trank            (m_axis_trank),
        .m_buffer_counter        (m_buffer_counter),
        .m_buffer_remain_size    (m_buffer_remain_size),
        .m_is_buffer_almost_full (m_is_buffer_almost_full),
        .m_is_pifo_full          (m_is_pifo_full)
    );

    //////////////////////////////////////////////////////////////////////
    // error reporting and compares
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp)
            abort_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_keep(input string name, input keep_t got, input keep_t exp);
        if (got !== exp)
            abort_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_rank(input string name, input rank_t got, input rank_t exp);
        if (got !== exp)
            abort_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_count(input string name, input count_t got, input count_t exp);
        if (got !== exp)
            abort_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
    endtask

    //////////////////////////////////////////////////////////////////////
    // model
    //////////////////////////////////////////////////////////////////////

    // lowest rank wins, strict compare keeps the earliest on a tie
    function automatic int best_pending();
        int best;
        best = 0;
        for (int i = 1; i < pending.size(); i++)
            if (pkt_rank[pending[i]] < pkt_rank[pending[best]])
                best = i;
        return best;
    endfunction

    function automatic int find_pending(input int id);
        int idx;
        idx = -1;
        for (int i = 0; i < pending.size(); i++)
            if (pending[i] == id)
                idx = i;
        return idx;
    endfunction

    function automatic int random_len();
        logic [31:0] r;
        r = $random(seed);
        return int'(r[15:0] % 16'd6) + 1;
    endfunction

    // one output word seen at the negedge before its transfer edge
    task automatic take_word();
        int idx;
        if (cur_id < 0)
        begin
            if (pending.size() == 0)
                abort_run("output word arrived with no packet stored in the model");
            else
            begin
                // packet id sits in the top byte of every word
                idx = ordered ? best_pending() : find_pending(int'(m_axis_tdata[31:24]));
                if (idx < 0)
                    abort_run("output packet is unknown or was already delivered");
                cur_id = pending[idx];
                pending.delete(idx);
                word_idx = 0;
            end
        end
        check_data("m_axis_tdata", m_axis_tdata, pkt_data[cur_id][word_idx]);
        check_keep("m_axis_tkeep", m_axis_tkeep, pkt_keep[cur_id][word_idx]);
        check_bit("m_axis_tlast", m_axis_tlast, word_idx == pkt_len[cur_id] - 1);
        check_rank("m_axis_trank", m_axis_trank, pkt_rank[cur_id]);
        word_idx++;
        if (m_axis_tlast)
            cur_id = -1;
    endtask

    //////////////////////////////////////////////////////////////////////
    // source side
    //////////////////////////////////////////////////////////////////////

    task automatic send_packet(input int len);
        logic [31:0] r;
        int          id;
        id = next_id;
        next_id++;
        r = $random(seed);
        // narrow rank range so ties are common
        pkt_rank[id] = rank_t'(r[3:0]);
        pkt_len[id]  = len;
        for (int w = 0; w < len; w++)
        begin
            r = $random(seed);
            pkt_data[id][w] = {id[7:0], r[23:0]};
            pkt_keep[id][w] = r[27:24];
        end
        pending.push_back(id);
        for (int w = 0; w < len; w++)
        begin
            @(posedge axis_aclk);
            s_axis_tvalid <= 1'b1;
            s_axis_tdata  <= pkt_data[id][w];
            s_axis_tkeep  <= pkt_keep[id][w];
            s_axis_tlast  <= (w == len - 1);
            s_axis_trank  <= pkt_rank[id];
        end
        @(posedge axis_aclk);
        s_axis_tvalid <= 1'b0;
        s_axis_tlast  <= 1'b0;
    endtask

    // called at a negedge, status already reflects the last packet
    task automatic wait_room(input int len);
        int cycles;
        cycles = 0;
        while (m_is_pifo_full || m_buffer_remain_size < count_t'(len))
        begin
            cycles++;
            if (cycles > WAIT_LIMIT)
                abort_run("timeout waiting for buffer space or a free calendar slot");
            @(negedge axis_aclk);
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (pending.size() != 0 || cur_id >= 0)
        begin
            @(negedge axis_aclk);
            cycles++;
            if (cycles > WAIT_LIMIT)
                abort_run("timeout waiting for the queue to drain");
        end
    endtask

    task automatic check_status(input int exp_words, input int exp_pkts);
        count_t exp_remain;
        repeat (2) @(posedge axis_aclk);
        @(negedge axis_aclk);
        exp_remain = count_t'(BUF_DEPTH - 1 - exp_words);
        check_count("m_buffer_counter", m_buffer_counter, count_t'(exp_words));
        check_count("m_buffer_remain_size", m_buffer_remain_size, exp_remain);
        check_bit("m_is_buffer_almost_full", m_is_buffer_almost_full,
                  exp_remain <= count_t'(ALMOST_FULL_MARGIN));
        check_bit("m_is_pifo_full", m_is_pifo_full, exp_pkts == PIFO_DEPTH);
    endtask

    //////////////////////////////////////////////////////////////////////
    // sink side and output monitor
    //////////////////////////////////////////////////////////////////////

    always @(posedge axis_aclk)
    begin
        if (ready_mode == 2)
        begin
            ready_rand = $random(seed);
            m_axis_tready <= ready_rand[0];
        end
        else
            m_axis_tready <= (ready_mode == 1);
    end

    always @(negedge axis_aclk)
    begin
        if (axis_resetn)
        begin
            // stalled word must hold until it transfers
            if (was_stalled)
            begin
                check_bit("m_axis_tvalid", m_axis_tvalid, 1'b1);
                check_data("m_axis_tdata", m_axis_tdata, held_data);
                check_keep("m_axis_tkeep", m_axis_tkeep, held_keep);
                check_bit("m_axis_tlast", m_axis_tlast, held_last);
                check_rank("m_axis_trank", m_axis_trank, held_rank);
            end
            if (m_axis_tvalid && m_axis_tready)
                take_word();
            was_stalled = m_axis_tvalid && !m_axis_tready;
            held_data   = m_axis_tdata;
            held_keep   = m_axis_tkeep;
            held_last   = m_axis_tlast;
            held_rank   = m_axis_trank;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        int len;
        int words;
        seed          = 32'hf0e7;
        next_id       = 0;
        axis_aclk     = 1'b0;
        axis_resetn   = 1'b0;
        s_axis_tvalid = 1'b0;
        s_axis_tdata  = '0;
        s_axis_tkeep  = '0;
        s_axis_tlast  = 1'b0;
        s_axis_trank  = '0;
        repeat (5) @(posedge axis_aclk);
        axis_resetn <= 1'b1;
        @(negedge axis_aclk);

        // state right after reset
        check_bit("m_axis_tvalid", m_axis_tvalid, 1'b0);
        check_status(0, 0);

        // sink stalled, fill the calendar
        words = 0;
        for (int n = 0; n < PIFO_DEPTH; n++)
        begin
            len = random_len();
            send_packet(len);
            words += len;
            check_status(words, n + 1);
        end

        // drain in rank order
        ready_mode = 1;
        wait_drain();
        check_status(0, 0);

        // second batch, drained with a random ready
        ready_mode = 0;
        for (int n = 0; n < PIFO_DEPTH; n++)
        begin
            @(negedge axis_aclk);
            len = random_len();
            wait_room(len);
            send_packet(len);
        end
        @(negedge axis_aclk);
        ready_mode = 2;
        wait_drain();
        check_status(0, 0);

        // enqueue and dequeue overlap, order no longer fixed
        ordered = 1'b0;
        for (int n = 0; n < 40; n++)
        begin
            @(negedge axis_aclk);
            len = random_len();
            wait_room(len);
            send_packet(len);
        end
        @(negedge axis_aclk);
        wait_drain();
        check_status(0, 0);

        $display("test passed");
        $finish;
    end

endmodule

// ==== src.f ====
source/stream_pkg.sv
source/storage_pkg.sv
source/free_list_manager.sv
source/pkt_buffer.sv
source/pifo_calendar.sv
source/dequeue_ctrl.sv
source/pkt_queue_top.sv
bench/tb_pkt_queue.sv

// ==== run.sh ====
#!/bin/sh
# build and run the packet queue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module tb_pkt_queue \
    -f src.f \
    --Mdir obj_dir -o tb_pkt_queue

# exit status is nonzero when the run ends in $fatal
./obj_dir/tb_pkt_queue
